//--- logic/spiPkg.sv
package spiPkg;

  // ********************************************************************
  // Register bus
  // ********************************************************************
  localparam int RegAddrW = 2;
  localparam int BusW     = 16;

  typedef logic [RegAddrW-1:0] regAddrT;
  typedef logic [BusW-1:0]     busDataT;

  // Strobe codes on wrEn and rdEn
  typedef logic [1:0] accessT;
  localparam accessT ByteAccess = 2'b01;
  localparam accessT WordAccess = 2'b11;

  // Byte addresses
  localparam regAddrT AddrCtrl = 2'd0;
  localparam regAddrT AddrBaud = 2'd1;
  localparam regAddrT AddrData = 2'd2;

  // Word addresses
  localparam regAddrT AddrPres = 2'd2;
  localparam regAddrT AddrTOut = 2'd3;

  // ********************************************************************
  // SPI engine and timer
  // ********************************************************************
  typedef logic [7:0]  spiByteT;
  typedef logic [7:0]  baudT;
  typedef logic [15:0] timerWordT;

  // Bit 1 idle clock level, bit 0 sample on second edge
  typedef logic [1:0] spiModeT;

  typedef struct packed {
    logic    csEn;
    logic    msbFirst;
    spiModeT mode;
  } spiCtrlT;

  // Half-bit steps loaded at transfer start
  localparam logic [3:0] BitCountInit = 4'd15;

endpackage

//--- logic/spiRegBank.sv
module spiRegBank
  import spiPkg::*;
(
  input  logic      AClkH,
  input  logic      AResetB,
  input  regAddrT   addr,
  input  accessT    wrEn,
  input  accessT    rdEn,
  input  busDataT   mosi,
  output busDataT   miso,
  output spiCtrlT   ctrl,
  output baudT      baud,
  output logic      startXfer,
  output spiByteT   txByte,
  output timerWordT presCfg,
  output timerWordT toutCfg,
  output logic      reload,
  input  logic      busy,
  input  spiByteT   rxByte,
  input  logic      timerNz
);

  logic byteWr;
  logic wordWr;
  logic byteRd;
  logic wordRd;

  // ********************************************************************
  // Access decode
  // ********************************************************************
  assign byteWr = (wrEn == ByteAccess);
  assign wordWr = (wrEn == WordAccess);
  assign byteRd = (rdEn == ByteAccess);
  assign wordRd = (rdEn == WordAccess);

  // Data byte write kicks the engine in the same cycle
  assign startXfer = byteWr && (addr == AddrData);
  assign txByte    = mosi[7:0];

  // Reading the timeout word rearms the timer
  assign reload = wordRd && (addr == AddrTOut);

  // ********************************************************************
  // Configuration registers
  // ********************************************************************
  always_ff @(posedge AClkH or negedge AResetB)
  begin
    if (!AResetB)
    begin
      ctrl    <= '0;
      baud    <= '0;
      presCfg <= '0;
      toutCfg <= '0;
    end
    else
    begin
      if (byteWr && (addr == AddrCtrl))
      begin
        // Control byte layout is msbFirst at 7, mode at 5:4, csEn at 0
        ctrl.msbFirst <= mosi[7];
        ctrl.mode     <= mosi[5:4];
        ctrl.csEn     <= mosi[0];
      end
      if (byteWr && (addr == AddrBaud))
      begin
        baud <= mosi[7:0];
      end
      if (wordWr && (addr == AddrPres))
      begin
        presCfg <= mosi;
      end
      if (wordWr && (addr == AddrTOut))
      begin
        toutCfg <= mosi;
      end
    end
  end

  // ********************************************************************
  // Read mux
  // ********************************************************************
  always_comb
  begin
    miso = '0;
    if (byteRd)
    begin
      case (addr)
        AddrCtrl: miso[7:0] = {busy, timerNz, ctrl.mode, 3'b000, ctrl.csEn};
        AddrBaud: miso[7:0] = baud;
        AddrData: miso[7:0] = rxByte;
        default:  miso = '0;
      endcase
    end
    else if (wordRd)
    begin
      case (addr)
        AddrPres: miso = presCfg;
        AddrTOut: miso = toutCfg;
        default:  miso = '0;
      endcase
    end
  end

endmodule

//--- logic/spiByteEngine.sv
module spiByteEngine
  import spiPkg::*;
(
  input  logic    AClkH,
  input  logic    AResetB,
  input  spiCtrlT ctrl,
  input  baudT    baud,
  input  logic    startXfer,
  input  spiByteT txByte,
  input  logic    spiMiso,
  output logic    spiSck,
  output logic    spiMosi,
  output logic    busy,
  output spiByteT rxByte
);

  logic [3:0] bitCount;
  logic [3:0] bitCountNext;
  baudT       baudDiv;
  baudT       baudDivNext;
  spiByteT    txShift;
  spiByteT    txNext;
  spiByteT    rxNext;
  logic       sckNext;
  logic       misoQ;
  logic       active;
  logic       step;
  logic       sampleStep;
  logic       shiftStep;

  function automatic spiByteT reverseByte(input spiByteT b);
    spiByteT r;
    for (int i = 0; i < 8; i++)
    begin
      r[i] = b[7-i];
    end
    return r;
  endfunction

  // ********************************************************************
  // Divider and half-bit counter
  // ********************************************************************
  assign active     = (bitCount != '0) || (baudDiv != '0);
  assign step       = active && (baudDiv == '0);
  // MISO goes through a register, so the loopback needs baud of at least 1
  assign sampleStep = step && bitCount[0];
  assign shiftStep  = step && !bitCount[0];

  always_comb
  begin
    if (startXfer)
    begin
      bitCountNext = BitCountInit;
      baudDivNext  = baud;
    end
    else
    begin
      bitCountNext = bitCount - 4'(step);
      if (baudDiv != '0)
        baudDivNext = baudDiv - 8'd1;
      else if (bitCount != '0)
        baudDivNext = baud;
      else
        baudDivNext = '0;
    end
  end

  // Shifters, LSB-first bytes are mirrored so MOSI always leaves from bit 7
  always_comb
  begin
    if (startXfer)
      txNext = ctrl.msbFirst ? txByte : reverseByte(txByte);
    else if (shiftStep)
      txNext = {txShift[6:0], 1'b0};
    else
      txNext = txShift;

    if (sampleStep)
      rxNext = ctrl.msbFirst ? {rxByte[6:0], misoQ} : {misoQ, rxByte[7:1]};
    else
      rxNext = rxByte;

    // Leading level puts the launch edge first in modes 1 and 3
    if (startXfer)
      sckNext = ctrl.mode[1] ^ ctrl.mode[0];
    else if (active)
      sckNext = spiSck ^ step;
    else
      sckNext = ctrl.mode[1];
  end

  always_ff @(posedge AClkH or negedge AResetB)
  begin
    if (!AResetB)
    begin
      bitCount <= '0;
      baudDiv  <= '0;
      txShift  <= '0;
      rxByte   <= '0;
      spiSck   <= 1'b0;
      misoQ    <= 1'b0;
      busy     <= 1'b0;
    end
    else
    begin
      bitCount <= bitCountNext;
      baudDiv  <= baudDivNext;
      txShift  <= txNext;
      rxByte   <= rxNext;
      spiSck   <= sckNext;
      misoQ    <= spiMiso;
      // Falls together with SCK returning to idle
      busy     <= active;
    end
  end

  assign spiMosi = txShift[7];

endmodule

//--- logic/spiTimeoutTimer.sv
module spiTimeoutTimer
  import spiPkg::*;
(
  input  logic      AClkH,
  input  logic      AResetB,
  input  timerWordT presCfg,
  input  timerWordT toutCfg,
  input  logic      reload,
  output logic      timerNz
);

  timerWordT presCnt;
  timerWordT toutCnt;
  timerWordT presNext;
  timerWordT toutNext;
  logic      presNz;
  logic      toutNz;

  assign presNz = (presCnt != '0);
  assign toutNz = (toutCnt != '0);

  always_comb
  begin
    if (reload)
    begin
      // Zero timeout leaves the timer disarmed
      presNext = (toutCfg != '0) ? presCfg : '0;
      toutNext = toutCfg;
    end
    else
    begin
      if (presNz)
        presNext = presCnt - 16'd1;
      else if (toutNz)
        presNext = presCfg;
      else
        presNext = '0;
      // One timeout tick per prescaler wrap
      toutNext = (toutNz && !presNz) ? toutCnt - 16'd1 : toutCnt;
    end
  end

  always_ff @(posedge AClkH or negedge AResetB)
  begin
    if (!AResetB)
    begin
      presCnt <= '0;
      toutCnt <= '0;
      timerNz <= 1'b0;
    end
    else
    begin
      presCnt <= presNext;
      toutCnt <= toutNext;
      timerNz <= (presNext != '0) || (toutNext != '0);
    end
  end

endmodule

//--- logic/spiPeriph.sv
module spiPeriph
  import spiPkg::*;
(
  input  logic    AClkH,
  input  logic    AResetB,
  input  regAddrT addr,
  input  accessT  wrEn,
  input  accessT  rdEn,
  input  busDataT mosi,
  output busDataT miso,
  output logic    spiSck,
  input  logic    spiMiso,
  output logic    spiMosi,
  output logic    spiCsB,
  output logic    timerNz
);

  spiCtrlT   ctrl;
  baudT      baud;
  logic      startXfer;
  spiByteT   txByte;
  timerWordT presCfg;
  timerWordT toutCfg;
  logic      reload;
  logic      busy;
  spiByteT   rxByte;

  // ********************************************************************
  // Register bank, byte engine and timer
  // ********************************************************************
  spiRegBank regBank0 (
    .AClkH     (AClkH),
    .AResetB   (AResetB),
    .addr      (addr),
    .wrEn      (wrEn),
    .rdEn      (rdEn),
    .mosi      (mosi),
    .miso      (miso),
    .ctrl      (ctrl),
    .baud      (baud),
    .startXfer (startXfer),
    .txByte    (txByte),
    .presCfg   (presCfg),
    .toutCfg   (toutCfg),
    .reload    (reload),
    .busy      (busy),
    .rxByte    (rxByte),
    .timerNz   (timerNz)
  );

  spiByteEngine byteEngine0 (
    .AClkH     (AClkH),
    .AResetB   (AResetB),
    .ctrl      (ctrl),
    .baud      (baud),
    .startXfer (startXfer),
    .txByte    (txByte),
    .spiMiso   (spiMiso),
    .spiSck    (spiSck),
    .spiMosi   (spiMosi),
    .busy      (busy),
    .rxByte    (rxByte)
  );

  spiTimeoutTimer timer0 (
    .AClkH   (AClkH),
    .AResetB (AResetB),
    .presCfg (presCfg),
    .toutCfg (toutCfg),
    .reload  (reload),
    .timerNz (timerNz)
  );

  // Chip select follows the enable bit straight from its register
  assign spiCsB = ~ctrl.csEn;

endmodule

//--- dv/clockGen.sv
module clockGen
(
  output logic AClkH,
  output logic AResetB
);

  timeunit 1ns;
  timeprecision 100ps;

  // Reset held low over the first two rising edges
  initial
  begin
    AClkH   = 1'b0;
    AResetB = 1'b0;
    repeat (2) @(posedge AClkH);
    @(negedge AClkH);
    AResetB = 1'b1;
  end

  // 20 ns period
  always #10 AClkH = ~AClkH;

endmodule

//--- dv/spiPeriph_chk.sv
module spiPeriph_chk
  import spiPkg::*;
(
  input logic    AClkH,
  input logic    AResetB,
  input regAddrT addr,
  input accessT  wrEn,
  input accessT  rdEn,
  input busDataT mosi,
  input busDataT miso,
  input logic    spiSck,
  input logic    spiMosi,
  input logic    spiCsB,
  input logic    timerNz,
  input logic    busy
);

  timeunit 1ns;
  timeprecision 100ps;

  int unsigned failCount = 0;

  spiCtrlT     expCtrl;
  baudT        expBaud;
  spiByteT     expTx;
  timerWordT   expPres;
  timerWordT   expTout;
  logic        xferSeen;
  logic        dataWrQ;
  int unsigned xferCycles;
  int unsigned timerCycles;
  logic        ctrlRd;
  logic        baudRd;
  logic        dataRd;
  logic        toutRd;
  logic        dataWr;

  assign ctrlRd = (rdEn == ByteAccess) && (addr == AddrCtrl);
  assign baudRd = (rdEn == ByteAccess) && (addr == AddrBaud);
  assign dataRd = (rdEn == ByteAccess) && (addr == AddrData);
  assign toutRd = (rdEn == WordAccess) && (addr == AddrTOut);
  assign dataWr = (wrEn == ByteAccess) && (addr == AddrData);

  // ********************************************************************
  // Expected register contents, taken from the bus writes
  // ********************************************************************
  always_ff @(posedge AClkH or negedge AResetB)
  begin
    if (!AResetB)
    begin
      expCtrl     <= '0;
      expBaud     <= '0;
      expTx       <= '0;
      expPres     <= '0;
      expTout     <= '0;
      xferSeen    <= 1'b0;
      dataWrQ     <= 1'b0;
      xferCycles  <= 0;
      timerCycles <= 0;
    end
    else
    begin
      if ((wrEn == ByteAccess) && (addr == AddrCtrl))
      begin
        expCtrl.msbFirst <= mosi[7];
        expCtrl.mode     <= mosi[5:4];
        expCtrl.csEn     <= mosi[0];
      end
      if ((wrEn == ByteAccess) && (addr == AddrBaud))
        expBaud <= mosi[7:0];
      if ((wrEn == WordAccess) && (addr == AddrPres))
        expPres <= mosi;
      if ((wrEn == WordAccess) && (addr == AddrTOut))
        expTout <= mosi;
      if (dataWr)
      begin
        expTx    <= mosi[7:0];
        xferSeen <= 1'b1;
      end
      dataWrQ <= dataWr;
      // Cycle counts since the last start and the last reload
      if (dataWr)
        xferCycles <= 0;
      else if (busy)
        xferCycles <= xferCycles + 1;
      if (toutRd)
        timerCycles <= 0;
      else if (timerNz)
        timerCycles <= timerCycles + 1;
    end
  end

  // ********************************************************************
  // Assertions
  // ********************************************************************
  resetPins: assert property (@(posedge AClkH)
    $rose(AResetB) |-> spiCsB && !spiSck && !timerNz)
    else
    begin
      failCount++;
      $error("Fail %0t: pins not at their reset levels", $time);
    end

  csFollows: assert property (@(posedge AClkH) disable iff (!AResetB)
    spiCsB == !expCtrl.csEn)
    else
    begin
      failCount++;
      $error("Fail %0t: spiCsB %b does not match csEn", $time, $sampled(spiCsB));
    end

  // Busy must read zero until the first transfer
  ctrlReadback: assert property (@(posedge AClkH) disable iff (!AResetB)
    ctrlRd |-> miso[5:4] == expCtrl.mode && miso[0] == expCtrl.csEn
      && miso[6] == timerNz && (xferSeen || !miso[7]))
    else
    begin
      failCount++;
      $error("Fail %0t: control readback %h", $time, $sampled(miso));
    end

  baudReadback: assert property (@(posedge AClkH) disable iff (!AResetB)
    baudRd |-> miso == busDataT'(expBaud))
    else
    begin
      failCount++;
      $error("Fail %0t: baud readback %h, expected %h", $time, $sampled(miso), expBaud);
    end

  toutReadback: assert property (@(posedge AClkH) disable iff (!AResetB)
    toutRd |-> miso == expTout)
    else
    begin
      failCount++;
      $error("Fail %0t: timeout readback %h, expected %h", $time, $sampled(miso), expTout);
    end

  // First bit on MOSI shows the chosen bit order
  firstBit: assert property (@(posedge AClkH) disable iff (!AResetB)
    dataWrQ |-> spiMosi == (expCtrl.msbFirst ? expTx[7] : expTx[0]))
    else
    begin
      failCount++;
      $error("Fail %0t: first MOSI bit %b for byte %h", $time, $sampled(spiMosi), expTx);
    end

  loopback: assert property (@(posedge AClkH) disable iff (!AResetB)
    dataRd && xferSeen && !busy && !dataWrQ |-> miso == busDataT'(expTx))
    else
    begin
      failCount++;
      $error("Fail %0t: received %h, expected %h", $time, $sampled(miso), expTx);
    end

  busyBound: assert property (@(posedge AClkH) disable iff (!AResetB)
    busy |-> xferCycles <= 16 * (32'(expBaud) + 1) + 2)
    else
    begin
      failCount++;
      $error("Fail %0t: transfer still busy after %0d cycles", $time, xferCycles);
    end

  // Skips the cycle where SCK still follows a fresh mode or start
  sckIdle: assert property (@(posedge AClkH) disable iff (!AResetB)
    xferSeen && !busy && !dataWrQ && $stable(expCtrl.mode) |-> spiSck == expCtrl.mode[1])
    else
    begin
      failCount++;
      $error("Fail %0t: idle SCK %b against mode %b", $time, $sampled(spiSck), expCtrl.mode);
    end

  timerArm: assert property (@(posedge AClkH) disable iff (!AResetB)
    toutRd |=> timerNz == (expTout != '0))
    else
    begin
      failCount++;
      $error("Fail %0t: timerNz %b after reload", $time, $sampled(timerNz));
    end

  timerBound: assert property (@(posedge AClkH) disable iff (!AResetB)
    timerNz |-> timerCycles <= (32'(expTout) + 1) * (32'(expPres) + 1) + 2)
    else
    begin
      failCount++;
      $error("Fail %0t: timerNz high for %0d cycles", $time, timerCycles);
    end

endmodule

bind spiPeriph spiPeriph_chk chk0 (
  .AClkH   (AClkH),
  .AResetB (AResetB),
  .addr    (addr),
  .wrEn    (wrEn),
  .rdEn    (rdEn),
  .mosi    (mosi),
  .miso    (miso),
  .spiSck  (spiSck),
  .spiMosi (spiMosi),
  .spiCsB  (spiCsB),
  .timerNz (timerNz),
  .busy    (busy)
);

//--- dv/spiPeriphTb.sv
module spiPeriphTb
  import spiPkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NumXfer   = 16;
  localparam int MaxBaud   = 8;
  localparam int NumTimer  = 6;
  localparam int MaxPres   = 3;
  localparam int MaxTout   = 6;
  localparam int XferLen   = 16 * (MaxBaud + 1) + 2;
  localparam int TimerLen  = (MaxTout + 1) * (MaxPres + 1) + 2;
  localparam int Overhead  = 40;
  localparam int WatchdogCycles =
    2 * (NumXfer * (XferLen + Overhead) + NumTimer * (TimerLen + Overhead) + Overhead);

  logic    AClkH;
  logic    AResetB;
  regAddrT addr;
  accessT  wrEn;
  accessT  rdEn;
  busDataT mosi;
  busDataT miso;
  logic    spiSck;
  logic    spiMiso;
  logic    spiMosi;
  logic    spiCsB;
  logic    timerNz;

  int unsigned lcgState   = 9160;
  int          tbErrors   = 0;
  int          xferCount  = 0;
  int          timerCount = 0;

  clockGen clockGen0 (
    .AClkH   (AClkH),
    .AResetB (AResetB)
  );

  spiPeriph dut0 (
    .AClkH   (AClkH),
    .AResetB (AResetB),
    .addr    (addr),
    .wrEn    (wrEn),
    .rdEn    (rdEn),
    .mosi    (mosi),
    .miso    (miso),
    .spiSck  (spiSck),
    .spiMiso (spiMiso),
    .spiMosi (spiMosi),
    .spiCsB  (spiCsB),
    .timerNz (timerNz)
  );

  // MOSI looped back into MISO
  assign spiMiso = spiMosi;

  function automatic int unsigned nextRandom();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState >> 16;
  endfunction

  // ********************************************************************
  // Bus access, one cycle per access
  // ********************************************************************
  task automatic busWrite(input regAddrT a, input accessT acc, input busDataT d);
    @(negedge AClkH);
    addr = a;
    wrEn = acc;
    mosi = d;
    @(negedge AClkH);
    wrEn = '0;
  endtask

  task automatic busRead(input regAddrT a, input accessT acc, output busDataT d);
    @(negedge AClkH);
    addr = a;
    rdEn = acc;
    @(negedge AClkH);
    d    = miso;
    rdEn = '0;
  endtask

  // Polls busy in the control byte
  task automatic waitBusy(input logic level);
    busDataT d;
    int      polls;
    polls = 0;
    do
    begin
      busRead(AddrCtrl, ByteAccess, d);
      polls++;
    end
    while (d[7] !== level && polls < XferLen);
    if (d[7] !== level)
    begin
      tbErrors++;
      $display("Busy never reached %0b within %0d polls at %0t", level, XferLen, $time);
    end
  endtask

  task automatic runTransfer(input int idx);
    spiModeT mode;
    logic    msbFirst;
    logic    csEn;
    baudT    baudVal;
    spiByteT txVal;
    busDataT d;
    // Walks all four modes for each bit order
    mode     = spiModeT'(idx % 4);
    msbFirst = idx[2];
    csEn     = logic'(nextRandom() % 2);
    baudVal  = baudT'(1 + nextRandom() % MaxBaud);
    txVal    = spiByteT'(nextRandom());
    busWrite(AddrCtrl, ByteAccess, {8'h00, msbFirst, 1'b0, mode, 3'b000, csEn});
    busRead(AddrCtrl, ByteAccess, d);
    busWrite(AddrBaud, ByteAccess, {8'h00, baudVal});
    busRead(AddrBaud, ByteAccess, d);
    busWrite(AddrData, ByteAccess, {8'h00, txVal});
    waitBusy(1'b1);
    waitBusy(1'b0);
    busRead(AddrData, ByteAccess, d);
    xferCount++;
  endtask

  task automatic runTimer(input timerWordT pres, input timerWordT tout);
    busDataT d;
    int      cycles;
    busWrite(AddrPres, WordAccess, pres);
    busWrite(AddrTOut, WordAccess, tout);
    busRead(AddrTOut, WordAccess, d);
    // Control read while the timer still runs
    busRead(AddrCtrl, ByteAccess, d);
    cycles = 0;
    while (timerNz && cycles < TimerLen + 4)
    begin
      @(negedge AClkH);
      cycles++;
    end
    if (timerNz)
    begin
      tbErrors++;
      $display("timerNz still high %0d cycles after reload at %0t", cycles, $time);
    end
    busRead(AddrCtrl, ByteAccess, d);
    timerCount++;
  endtask

  // ********************************************************************
  // Stimulus and closing report
  // ********************************************************************
  initial
  begin
    busDataT   d;
    timerWordT pres;
    timerWordT tout;
    addr = '0;
    wrEn = '0;
    rdEn = '0;
    mosi = '0;
    wait (AResetB === 1'b1);
    busRead(AddrCtrl, ByteAccess, d);
    for (int i = 0; i < NumXfer; i++)
      runTransfer(i);
    for (int j = 0; j < NumTimer; j++)
    begin
      pres = timerWordT'(nextRandom() % (MaxPres + 1));
      tout = timerWordT'(1 + nextRandom() % MaxTout);
      runTimer(pres, tout);
    end
    // Zero timeout leaves the flag low
    runTimer(16'h0003, 16'h0000);
    repeat (4) @(negedge AClkH);
    $display("Summary: %0d transfers, %0d timer runs, %0d assertion failures, %0d tb errors",
             xferCount, timerCount, dut0.chk0.failCount, tbErrors);
    if (dut0.chk0.failCount == 0 && tbErrors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

  initial
  begin
    repeat (WatchdogCycles) @(posedge AClkH);
    $display("Watchdog expired after %0d cycles, run stopped", WatchdogCycles);
    $display("TEST FAIL");
    $finish;
  end

endmodule

//--- build.f
logic/spiPkg.sv
logic/spiRegBank.sv
logic/spiByteEngine.sv
logic/spiTimeoutTimer.sv
logic/spiPeriph.sv
dv/clockGen.sv
dv/spiPeriph_chk.sv
dv/spiPeriphTb.sv

//--- Bender.yml
package:
  name: spi_periph

sources:
  - logic/spiPkg.sv
  - logic/spiRegBank.sv
  - logic/spiByteEngine.sv
  - logic/spiTimeoutTimer.sv
  - logic/spiPeriph.sv
  - target: test
    files:
      - dv/clockGen.sv
      - dv/spiPeriph_chk.sv
      - dv/spiPeriphTb.sv
